/* src/board_pkg.sv */
package board_pkg;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_NOT = 3'd2,
        ALU_AND = 3'd3,
        ALU_OR  = 3'd4,
        ALU_XOR = 3'd5,
        ALU_LT  = 3'd6,  // Signed compare
        ALU_EQ  = 3'd7
    } alu_op_e;

    typedef struct packed {
        logic [3:0] val;
        logic       zero;
        logic       carry;
        logic       overflow;
    } alu_out_t;

    typedef struct packed {
        logic [2:0] idx;
        logic       valid;
    } enc_out_t;

    // Active low, dp in bit 7, segments g..a in bits 6..0
    typedef logic [7:0] seg_t;

    localparam int   SEG_DIGITS = 8;
    localparam seg_t SEG_BLANK  = 8'hff;
    localparam seg_t SEG_DP     = 8'h7f;  // Only the dot lit

endpackage

/* src/video_pkg.sv */
package video_pkg;

    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BACK   = 48;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;  // 800

    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;  // 525

    typedef struct packed {
        logic [9:0] h;
        logic [9:0] v;
    } pix_pos_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    localparam int TILE_WORDS = 32;

endpackage

/* src/alu_4bit.sv */
`timescale 1ns/1ps

module alu_4bit import board_pkg::*; (
    input  alu_op_e    op,
    input  logic [3:0] a,
    input  logic [3:0] b,
    output alu_out_t   res
);

    logic [3:0] b_eff;
    logic [4:0] sum;
    logic [3:0] result;
    logic       carry;
    logic       overflow;

    always_comb begin
        b_eff = (op == ALU_SUB) ? ~b : b;  // Subtract as a + ~b + 1
        sum = {1'b0, a} + {1'b0, b_eff} + {4'd0, op == ALU_SUB};
        result = 4'd0;
        carry = 1'b0;
        overflow = 1'b0;
        case (op)
            ALU_ADD, ALU_SUB: begin
                result = sum[3:0];
                carry = sum[4];
                overflow = (a[3] == b_eff[3]) && (sum[3] != a[3]);
            end
            ALU_NOT: result = ~a;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_LT:  result = {3'd0, $signed(a) < $signed(b)};
            ALU_EQ:  result = {3'd0, a == b};
            default: result = 4'd0;
        endcase
    end

    assign res = '{
        val:      result,
        zero:     (result == 4'd0),
        carry:    carry,
        overflow: overflow
    };

endmodule

/* src/encoder83.sv */
`timescale 1ns/1ps

module encoder83 import board_pkg::*; (
    input  logic       en,
    input  logic [7:0] x,
    output enc_out_t   y
);

    always_comb begin
        y.idx = 3'd0;
        y.valid = 1'b0;
        if (en) begin
            for (int i = 0; i < 8; i++) begin
                if (x[i]) begin  // Later bits overwrite, highest wins
                    y.idx = 3'(i);
                    y.valid = 1'b1;
                end
            end
        end
    end

endmodule

/* src/seg_display.sv */
`timescale 1ns/1ps

module seg_display import board_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  alu_out_t               alu,
    input  enc_out_t               enc,
    output seg_t [SEG_DIGITS-1:0]  seg
);

    seg_t [SEG_DIGITS-1:0] seg_next;

    function automatic seg_t hex_to_seg(input logic [3:0] v);
        case (v)
            4'h0: return 8'hc0;
            4'h1: return 8'hf9;
            4'h2: return 8'ha4;
            4'h3: return 8'hb0;
            4'h4: return 8'h99;
            4'h5: return 8'h92;
            4'h6: return 8'h82;
            4'h7: return 8'hf8;
            4'h8: return 8'h80;
            4'h9: return 8'h90;
            4'ha: return 8'h88;
            4'hb: return 8'h83;
            4'hc: return 8'hc6;
            4'hd: return 8'ha1;
            4'he: return 8'h86;
            default: return 8'h8e;
        endcase
    endfunction

    always_comb begin
        seg_next = {SEG_DIGITS{SEG_BLANK}};
        seg_next[0] = hex_to_seg(alu.val);
        seg_next[1] = hex_to_seg({1'b0, alu.zero, alu.carry, alu.overflow});
        seg_next[2] = hex_to_seg({1'b0, enc.idx});
        seg_next[3] = enc.valid ? SEG_DP : SEG_BLANK;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seg <= {SEG_DIGITS{SEG_BLANK}};
        end else begin
            seg <= seg_next;
        end
    end

endmodule

/* src/vga_ctrl.sv */
`timescale 1ns/1ps

module vga_ctrl import video_pkg::*; (
    input  logic     pclk,
    input  logic     rst_n,
    input  rgb_t     pixel,
    output pix_pos_t pos,
    output logic     hsync,
    output logic     vsync,
    output logic     valid,
    output rgb_t     colour
);

    logic [9:0] h_cnt;
    logic [9:0] v_cnt;
    logic       h_wrap;

    assign h_wrap = (h_cnt == 10'(H_TOTAL - 1));

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            h_cnt <= 10'd0;
        end else if (h_wrap) begin
            h_cnt <= 10'd0;
        end else begin
            h_cnt <= h_cnt + 10'd1;
        end
    end

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            v_cnt <= 10'd0;
        end else if (h_wrap) begin  // One line done
            if (v_cnt == 10'(V_TOTAL - 1)) begin
                v_cnt <= 10'd0;
            end else begin
                v_cnt <= v_cnt + 10'd1;
            end
        end
    end

    assign pos = '{h: h_cnt, v: v_cnt};

    // Sync pulses sit between front and back porch
    assign hsync = !((h_cnt >= 10'(H_ACTIVE + H_FRONT)) &&
                     (h_cnt <  10'(H_ACTIVE + H_FRONT + H_SYNC)));
    assign vsync = !((v_cnt >= 10'(V_ACTIVE + V_FRONT)) &&
                     (v_cnt <  10'(V_ACTIVE + V_FRONT + V_SYNC)));

    assign valid  = (h_cnt < 10'(H_ACTIVE)) && (v_cnt < 10'(V_ACTIVE));
    assign colour = valid ? pixel : '0;  // Black while blanked

endmodule

/* src/vmem.sv */
`timescale 1ns/1ps

module vmem import video_pkg::*; (
    input  pix_pos_t pos,
    output rgb_t     pixel
);

    rgb_t                          mem [TILE_WORDS];
    logic [$clog2(TILE_WORDS)-1:0] addr;

    initial begin
        $readmemh("resource/picture.hex", mem);
    end

    // 128x128 pixel tiles, row-major
    assign addr  = {pos.v[8:7], pos.h[9:7]};
    assign pixel = mem[addr];

endmodule

/* src/board_top.sv */
`timescale 1ns/1ps

module board_top import board_pkg::*, video_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [2:0] alu_fnselec,
    input  logic [3:0] alu_a,
    input  logic [3:0] alu_b,
    input  logic [7:0] ec_x,
    input  logic       ec_en,
    output logic [3:0] alu_res,
    output logic       alu_zero,
    output logic       alu_carry,
    output logic       alu_overflow,
    output logic [2:0] ec_y,
    output logic       ec_valid,
    output seg_t       seg0,
    output seg_t       seg1,
    output seg_t       seg2,
    output seg_t       seg3,
    output seg_t       seg4,
    output seg_t       seg5,
    output seg_t       seg6,
    output seg_t       seg7,
    output logic       vga_clk,
    output logic       vga_hsync,
    output logic       vga_vsync,
    output logic       vga_blank_n,
    output logic [7:0] vga_r,
    output logic [7:0] vga_g,
    output logic [7:0] vga_b
);

    alu_out_t              alu_w;
    enc_out_t              enc_w;
    seg_t [SEG_DIGITS-1:0] seg_w;
    pix_pos_t              pos_w;
    rgb_t                  pixel_w;
    rgb_t                  colour_w;

    alu_4bit alu_i (
        .op  (alu_op_e'(alu_fnselec)),
        .a   (alu_a),
        .b   (alu_b),
        .res (alu_w)
    );

    encoder83 enc_i (
        .en (ec_en),
        .x  (ec_x),
        .y  (enc_w)
    );

    seg_display seg_i (
        .clk   (clk),
        .rst_n (rst_n),
        .alu   (alu_w),
        .enc   (enc_w),
        .seg   (seg_w)
    );

    vga_ctrl vga_i (
        .pclk   (clk),
        .rst_n  (rst_n),
        .pixel  (pixel_w),
        .pos    (pos_w),
        .hsync  (vga_hsync),
        .vsync  (vga_vsync),
        .valid  (vga_blank_n),
        .colour (colour_w)
    );

    vmem vmem_i (
        .pos   (pos_w),
        .pixel (pixel_w)
    );

    assign alu_res      = alu_w.val;
    assign alu_zero     = alu_w.zero;
    assign alu_carry    = alu_w.carry;
    assign alu_overflow = alu_w.overflow;

    assign ec_y     = enc_w.idx;
    assign ec_valid = enc_w.valid;

    assign seg0 = seg_w[0];
    assign seg1 = seg_w[1];
    assign seg2 = seg_w[2];
    assign seg3 = seg_w[3];
    assign seg4 = seg_w[4];
    assign seg5 = seg_w[5];
    assign seg6 = seg_w[6];
    assign seg7 = seg_w[7];

    assign vga_clk = clk;  // Pixel clock straight to the DAC
    assign vga_r   = colour_w.r;
    assign vga_g   = colour_w.g;
    assign vga_b   = colour_w.b;

endmodule

/* test/tb_board_top.sv */
`timescale 1ns/1ps

module tb_board_top import board_pkg::*, video_pkg::*;;

    localparam int FRAME_CYCLES     = H_TOTAL * V_TOTAL;
    localparam int VGA_CHECK_CYCLES = FRAME_CYCLES + H_TOTAL;  // Frame plus next first line
    localparam int WATCHDOG_CYCLES  = 2 * FRAME_CYCLES + 2000;
    // Lit segments gfedcba for 0..F
    localparam logic [6:0] LIT [16] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
                                        7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic valid;
        rgb_t colour;
    } vga_exp_t;

    logic       clk, rst_n, ec_en;
    logic [2:0] alu_fnselec;
    logic [3:0] alu_a, alu_b, alu_res;
    logic [7:0] ec_x;
    logic       alu_zero, alu_carry, alu_overflow, ec_valid;
    logic [2:0] ec_y;
    seg_t       seg_pins [SEG_DIGITS];
    logic       vga_clk, vga_hsync, vga_vsync, vga_blank_n;
    logic [7:0] vga_r, vga_g, vga_b;
    rgb_t       pic [TILE_WORDS];
    logic       vga_done = 1'b0;

    board_top dut_i (.*,
        .seg0(seg_pins[0]), .seg1(seg_pins[1]), .seg2(seg_pins[2]), .seg3(seg_pins[3]),
        .seg4(seg_pins[4]), .seg5(seg_pins[5]), .seg6(seg_pins[6]), .seg7(seg_pins[7]));

    always #50 clk = ~clk;

    function automatic alu_out_t alu_model(input alu_op_e op, input logic [3:0] a,
                                           input logic [3:0] b);
        alu_out_t r;
        int       sa;
        int       sb;
        sa = $signed(a);
        sb = $signed(b);
        r = '0;
        case (op)
            ALU_ADD: begin
                r.val = a + b;
                r.carry = (int'(a) + int'(b)) > 15;
                r.overflow = (sa + sb > 7) || (sa + sb < -8);
            end
            ALU_SUB: begin
                r.val = a - b;
                r.carry = (a >= b);  // No borrow
                r.overflow = (sa - sb > 7) || (sa - sb < -8);
            end
            ALU_NOT: r.val = ~a;
            ALU_AND: r.val = a & b;
            ALU_OR:  r.val = a | b;
            ALU_XOR: r.val = a ^ b;
            ALU_LT:  r.val = (sa < sb) ? 4'd1 : 4'd0;
            default: r.val = (a == b) ? 4'd1 : 4'd0;
        endcase
        r.zero = (r.val == 4'd0);
        return r;
    endfunction

    function automatic enc_out_t enc_model(input logic en, input logic [7:0] x);
        enc_out_t r;
        r = '0;
        for (int i = 7; i >= 0; i--) begin
            if (en && x[i] && !r.valid) begin  // First hit from the top
                r.idx = 3'(i);
                r.valid = 1'b1;
            end
        end
        return r;
    endfunction

    function automatic seg_t seg_model(input alu_out_t alu, input enc_out_t enc, input int d);
        case (d)
            0: return {1'b1, ~LIT[alu.val]};
            1: return {1'b1, ~LIT[{1'b0, alu.zero, alu.carry, alu.overflow}]};
            2: return {1'b1, ~LIT[{1'b0, enc.idx}]};
            3: return enc.valid ? 8'h7f : 8'hff;
            default: return 8'hff;
        endcase
    endfunction

    function automatic vga_exp_t vga_model(input int n);
        vga_exp_t e;
        int       h;
        int       v;
        h = n % H_TOTAL;
        v = (n / H_TOTAL) % V_TOTAL;
        e.hsync = !(h >= H_ACTIVE + H_FRONT && h < H_ACTIVE + H_FRONT + H_SYNC);
        e.vsync = !(v >= V_ACTIVE + V_FRONT && v < V_ACTIVE + V_FRONT + V_SYNC);
        e.valid = (h < H_ACTIVE) && (v < V_ACTIVE);
        e.colour = e.valid ? pic[(v / 128) * 8 + h / 128] : '0;
        return e;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("=== FAIL ===");
        $fatal(1, "Stopped at first mismatch");
    endtask

    task automatic check_alu(input alu_out_t got, input alu_out_t want, input string op);
        if (got !== want)
            report_mismatch($sformatf("ALU %s got %b expected %b (val,z,c,v)", op, got, want));
    endtask

    task automatic check_enc(input enc_out_t got, input enc_out_t want);
        if (got !== want)
            report_mismatch($sformatf("encoder got %b expected %b (idx,valid)", got, want));
    endtask

    task automatic check_seg(input seg_t got, input seg_t want, input int d);
        if (got !== want)
            report_mismatch($sformatf("digit %0d got %h expected %h", d, got, want));
    endtask

    task automatic check_vga(input logic hs, input logic vs, input logic vld, input rgb_t col,
                             input vga_exp_t want, input int n);
        if ({hs, vs, vld, col} !== want)
            report_mismatch($sformatf("VGA h=%0d v=%0d got %b/%b/%b %h expected %b/%b/%b %h",
                n % H_TOTAL, (n / H_TOTAL) % V_TOTAL, hs, vs, vld, col,
                want.hsync, want.vsync, want.valid, want.colour));
    endtask

    task automatic check_clk(input logic got, input logic want);
        if (got !== want)
            report_mismatch($sformatf("vga_clk got %b expected %b", got, want));
    endtask

    task automatic apply_vector(input alu_op_e op, input logic [3:0] a, input logic [3:0] b,
                                input logic [7:0] x, input logic en);
        alu_out_t want_alu;
        enc_out_t want_enc;
        @(posedge clk);
        #10;
        alu_fnselec = op;
        alu_a = a;
        alu_b = b;
        ec_x = x;
        ec_en = en;
        want_alu = alu_model(op, a, b);
        want_enc = enc_model(en, x);
        @(negedge clk);
        check_alu('{alu_res, alu_zero, alu_carry, alu_overflow}, want_alu, op.name());
        check_enc('{ec_y, ec_valid}, want_enc);
        @(posedge clk);  // Display takes the new value here
        @(negedge clk);
        for (int d = 0; d < SEG_DIGITS; d++)
            check_seg(seg_pins[d], seg_model(want_alu, want_enc, d), d);
    endtask

    initial begin
        logic [3:0] a;
        logic [3:0] b;
        logic [7:0] x;
        void'($urandom(32'h6730fcf3));
        $readmemh("resource/picture.hex", pic);
        clk = 1'b0;
        rst_n = 1'b0;
        alu_fnselec = 3'd0;
        alu_a = 4'd0;
        alu_b = 4'd0;
        ec_x = 8'd0;
        ec_en = 1'b0;
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            #10;
            for (int d = 0; d < SEG_DIGITS; d++)
                check_seg(seg_pins[d], 8'hff, d);
        end
        rst_n = 1'b1;
        apply_vector(ALU_ADD, 4'd7, 4'd1, 8'h00, 1'b0);
        apply_vector(ALU_SUB, 4'd8, 4'd1, 8'h00, 1'b1);
        apply_vector(ALU_ADD, 4'd15, 4'd1, 8'h00, 1'b0);
        apply_vector(ALU_SUB, 4'd0, 4'd1, 8'h00, 1'b1);
        for (int i = 0; i < 300; i++) begin
            a = 4'($urandom);
            b = 4'($urandom);
            for (int k = 0; k < 8; k++)
                apply_vector(alu_op_e'(k), a, b, 8'($urandom), 1'($urandom));
        end
        for (int i = 0; i < 8; i++) begin
            apply_vector(ALU_OR, 4'($urandom), 4'($urandom), 8'(1 << i), 1'b1);
            apply_vector(ALU_OR, 4'($urandom), 4'($urandom), 8'(1 << i), 1'b0);
        end
        for (int i = 0; i < 100; i++) begin
            x = (i == 0) ? 8'h00 : 8'($urandom);
            apply_vector(ALU_XOR, 4'($urandom), 4'($urandom), x, 1'b1);
            apply_vector(ALU_XOR, 4'($urandom), 4'($urandom), x, 1'b0);
        end
        wait (vga_done);
        $display("=== PASS ===");
        $finish;
    end

    // Pixel counter n starts at 0 in the first cycle after reset release
    initial begin
        wait (rst_n === 1'b1);
        for (int n = 0; n < VGA_CHECK_CYCLES; n++) begin
            @(negedge clk);
            check_vga(vga_hsync, vga_vsync, vga_blank_n, '{vga_r, vga_g, vga_b},
                      vga_model(n), n);
            #10;
            check_clk(vga_clk, 1'b0);
            @(posedge clk);
            #10;
            check_clk(vga_clk, 1'b1);  // Pixel clock follows clk
        end
        vga_done = 1'b1;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $fatal(1, "Watchdog expired");
    end

endmodule

/* resource/picture.hex */
// One rrggbb colour word per 128x128 tile, address = {v[8:7], h[9:7]}
00ff20
08f727
10ef2e
18e735
20df3c
28d743
30cf4a
38c751
40bf58
48b75f
50af66
58a76d
609f74
68977b
708f82
788789
807f90
887797
906f9e
9867a5
a05fac
a857b3
b04fba
b847c1
c03fc8
c837cf
d02fd6
d827dd
e01fe4
e817eb
f00ff2
f807f9

/* filelist.f */
src/board_pkg.sv
src/video_pkg.sv
src/alu_4bit.sv
src/encoder83.sv
src/seg_display.sv
src/vga_ctrl.sv
src/vmem.sv
src/board_top.sv
test/tb_board_top.sv

/* Bender.yml */
package:
  name: teaching_board

sources:
  - src/board_pkg.sv
  - src/video_pkg.sv
  - src/alu_4bit.sv
  - src/encoder83.sv
  - src/seg_display.sv
  - src/vga_ctrl.sv
  - src/vmem.sv
  - src/board_top.sv
  - target: test
    files:
      - test/tb_board_top.sv
